// File: verilog.f
hw/core_pkg.sv
hw/ex_ops_pkg.sv
hw/ex_issue_reg.sv
hw/ex_alu.sv
hw/ex_mult.sv
hw/ex_stage.sv
hw/ex_top.sv
tb/tb_clkgen.sv
tb/ex_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the execute-stage testbench with Verilator, run it and scan the log
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -j 0 --top-module ex_tb -f verilog.f --Mdir obj_dir -o ex_sim

# The simulator exit code is not used, the log decides
./obj_dir/ex_sim | tee sim.log

if grep -q "FAIL: see errors above" sim.log; then
  echo "Simulation failed"
  exit 1
fi

if ! grep -q "PASS: all tests" sim.log; then
  echo "Simulation ended without a result"
  exit 1
fi

echo "Simulation passed"

// File: tb/ex_tb.sv
// Random-stimulus testbench for the execute stage, checked against a cycle model of EX occupancy
`timescale 1ns/1ps

module ex_tb
  import ex_ops_pkg::*, core_pkg::*;
();

  // Each instruction needs at most 4 cycles, stalls get generous slack
  localparam int N_INSTR        = 400;
  localparam int MAX_INSTR_CYC  = 4;
  localparam int STALL_SLACK    = 4400;
  localparam int TIMEOUT_CYCLES = N_INSTR * MAX_INSTR_CYC + STALL_SLACK;

  logic      clk;
  logic      rst_n;

  // Decode side, driven on the falling edge
  logic      issue_valid;
  alu_op_e   alu_op;
  logic      mult_en;
  mult_op_e  mult_op;
  word_t     opa;
  word_t     opb;
  word_t     opc;
  logic      branch;
  logic      csr_access;
  word_t     csr_rdata;
  logic      rf_we;
  reg_addr_t rf_waddr;
  logic      lsu_ready;
  logic      wb_ready;

  // DUT outputs
  logic      issue_ready;
  logic      fw_we;
  reg_addr_t fw_waddr;
  word_t     fw_wdata;
  logic      branch_valid;
  logic      branch_decision;
  word_t     jump_target;
  logic      wb_we;
  reg_addr_t wb_waddr;
  word_t     wb_wdata;
  logic      mult_multicycle;

  integer    seed;
  int        cycle_count = 0;
  int        accepted_count = 0;
  int        tail;
  logic      taken;
  logic      multicycle_seen = 1'b0;
  logic      end_ok;

  // Model of the instruction sitting in EX
  logic      m_busy = 1'b0;
  logic      m_branch = 1'b0;
  logic      m_high = 1'b0;
  logic      m_rf_we = 1'b0;
  reg_addr_t m_waddr = '0;
  word_t     m_wdata = '0;
  int        m_age = 0;

  // Expected results in issue order
  reg_addr_t wq_addr[$];
  word_t     wq_data[$];
  logic      bq_dec[$];
  word_t     bq_tgt[$];

  tb_clkgen clkgen0 (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  ex_top dut0 (
    .clk               (clk),
    .rst_n             (rst_n),
    .issue_valid_i     (issue_valid),
    .alu_op_i          (alu_op),
    .mult_en_i         (mult_en),
    .mult_op_i         (mult_op),
    .opa_i             (opa),
    .opb_i             (opb),
    .opc_i             (opc),
    .branch_i          (branch),
    .csr_access_i      (csr_access),
    .csr_rdata_i       (csr_rdata),
    .rf_we_i           (rf_we),
    .rf_waddr_i        (rf_waddr),
    .issue_ready_o     (issue_ready),
    .lsu_ready_i       (lsu_ready),
    .wb_ready_i        (wb_ready),
    .fw_we_o           (fw_we),
    .fw_waddr_o        (fw_waddr),
    .fw_wdata_o        (fw_wdata),
    .branch_valid_o    (branch_valid),
    .branch_decision_o (branch_decision),
    .jump_target_o     (jump_target),
    .wb_we_o           (wb_we),
    .wb_waddr_o        (wb_waddr),
    .wb_wdata_o        (wb_wdata),
    .mult_multicycle_o (mult_multicycle)
  );

  //////////////////////////////////////////////////////////////////////
  // Reference arithmetic
  //////////////////////////////////////////////////////////////////////

  function automatic word_t alu_expected(input alu_op_e op, input word_t a, input word_t b);
    word_t r;
    case (op)
      ALU_ADD:  r = a + b;
      ALU_SUB:  r = a - b;
      ALU_AND:  r = a & b;
      ALU_OR:   r = a | b;
      ALU_XOR:  r = a ^ b;
      ALU_SLL:  r = a << b[4:0];
      ALU_SRL:  r = a >> b[4:0];
      ALU_SRA:  r = word_t'($signed(a) >>> b[4:0]);
      ALU_SLT:  r = {{(XLEN-1){1'b0}}, ($signed(a) < $signed(b))};
      ALU_SLTU: r = {{(XLEN-1){1'b0}}, (a < b)};
      // Branch compares write nothing useful
      default:  r = '0;
    endcase
    return r;
  endfunction

  function automatic logic branch_expected(input alu_op_e op, input word_t a, input word_t b);
    logic taken_cmp;
    case (op)
      ALU_EQ:  taken_cmp = (a == b);
      ALU_NE:  taken_cmp = (a != b);
      ALU_LT:  taken_cmp = ($signed(a) < $signed(b));
      ALU_GE:  taken_cmp = ($signed(a) >= $signed(b));
      default: taken_cmp = 1'b0;
    endcase
    return taken_cmp;
  endfunction

  // Low 64 bits of the extended product are exact for every sign mix
  function automatic word_t mult_expected(input mult_op_e op, input word_t a, input word_t b);
    logic [63:0] ea;
    logic [63:0] eb;
    logic [63:0] p;
    ea = {32'b0, a};
    eb = {32'b0, b};
    if (op == MUL_HSS || op == MUL_HSU)
    begin
      ea = {{32{a[31]}}, a};
    end
    if (op == MUL_HSS)
    begin
      eb = {{32{b[31]}}, b};
    end
    p = ea * eb;
    return (op == MUL_LO) ? p[31:0] : p[63:32];
  endfunction

  function automatic int rand_below(input int n);
    logic [31:0] r;
    r = $random(seed);
    return int'(r % n);
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Compare tasks
  //////////////////////////////////////////////////////////////////////

  task automatic stop_on_error();
    $display("FAIL: see errors above");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp)
    begin
      $display("CHECK FAILED time=%0t signal=%s got=%h expected=%h", $time, name, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_addr(input string name, input reg_addr_t got, input reg_addr_t exp);
    if (got !== exp)
    begin
      $display("CHECK FAILED time=%0t signal=%s got=%h expected=%h", $time, name, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      $display("CHECK FAILED time=%0t signal=%s got=%b expected=%b", $time, name, got, exp);
      stop_on_error();
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Per-cycle checking at the rising edge
  //////////////////////////////////////////////////////////////////////

  task automatic check_cycle();
    logic  mult_ready_m;
    logic  ready_m;
    word_t exp_data;
    // High product holds the stage for its first two cycles in EX
    mult_ready_m = !(m_busy && m_high) || (m_age >= 2);
    ready_m = (mult_ready_m && lsu_ready && wb_ready) || (m_busy && m_branch) ||
              (!m_busy && wb_ready);
    check_bit("issue_ready_o", issue_ready, ready_m);
    check_bit("mult_multicycle_o", mult_multicycle, m_busy && m_high && (m_age >= 1));
    check_bit("branch_valid_o", branch_valid, m_busy && m_branch);
    check_bit("fw_we_o", fw_we, m_busy && !m_branch && m_rf_we);
    // Forwarded word is final once the multiplier stops holding the stage
    if (m_busy && !m_branch && m_rf_we && mult_ready_m)
    begin
      check_addr("fw_waddr_o", fw_waddr, m_waddr);
      check_word("fw_wdata_o", fw_wdata, m_wdata);
    end
    if (mult_multicycle)
    begin
      multicycle_seen = 1'b1;
    end
    // Branch outcome leaves EX at this edge
    if (branch_valid && issue_ready)
    begin
      if (bq_dec.size() == 0)
      begin
        $display("Branch reported in EX while no branch was issued");
        stop_on_error();
      end
      else
      begin
        check_bit("branch_decision_o", branch_decision, bq_dec.pop_front());
        check_word("jump_target_o", jump_target, bq_tgt.pop_front());
      end
    end
    // WB takes the write when it is ready
    if (wb_we && wb_ready)
    begin
      if (wq_addr.size() == 0)
      begin
        $display("Register write seen on the writeback port with no write outstanding");
        stop_on_error();
      end
      else
      begin
        check_addr("wb_waddr_o", wb_waddr, wq_addr.pop_front());
        check_word("wb_wdata_o", wb_wdata, wq_data.pop_front());
      end
    end
    taken = issue_valid && ready_m;
    if (ready_m)
    begin
      m_busy   = issue_valid;
      m_branch = issue_valid && branch;
      m_high   = issue_valid && mult_en && (mult_op != MUL_LO);
      m_rf_we  = issue_valid && rf_we;
      m_age    = 0;
      if (issue_valid)
      begin
        accepted_count++;
        if (branch)
        begin
          bq_dec.push_back(branch_expected(alu_op, opa, opb));
          bq_tgt.push_back(opc);
        end
        else if (rf_we)
        begin
          // Multiplier wins over CSR, CSR over ALU
          if (mult_en)
            exp_data = mult_expected(mult_op, opa, opb);
          else if (csr_access)
            exp_data = csr_rdata;
          else
            exp_data = alu_expected(alu_op, opa, opb);
          m_waddr = rf_waddr;
          m_wdata = exp_data;
          wq_addr.push_back(rf_waddr);
          wq_data.push_back(exp_data);
        end
      end
    end
    else if (m_busy)
    begin
      m_age++;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Stimulus at the falling edge
  //////////////////////////////////////////////////////////////////////

  task automatic drive_inputs();
    int cls;
    lsu_ready = (rand_below(100) < 80);
    wb_ready  = (rand_below(100) < 80);
    // A refused offer stays on the bus unchanged
    if (!issue_valid || taken)
    begin
      issue_valid = 1'b0;
      if (accepted_count < N_INSTR && rand_below(100) < 70)
      begin
        // 40% ALU, 20% branch, 20% CSR, 20% multiply
        cls         = rand_below(10);
        issue_valid = 1'b1;
        opa         = $random(seed);
        opb         = (rand_below(4) == 0) ? opa : $random(seed);
        opc         = $random(seed);
        csr_rdata   = $random(seed);
        rf_waddr    = reg_addr_t'(rand_below(32));
        mult_op     = mult_op_e'(2'(rand_below(4)));
        branch      = (cls == 4 || cls == 5);
        csr_access  = (cls == 6 || cls == 7);
        mult_en     = (cls >= 8);
        if (branch)
        begin
          alu_op = alu_op_e'(4'(10 + rand_below(4)));
          rf_we  = (rand_below(2) == 1);
        end
        else
        begin
          alu_op = alu_op_e'(4'(rand_below(10)));
          rf_we  = 1'b1;
        end
      end
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////

  initial
  begin
    seed        = 32'h95c7ed97;
    issue_valid = 1'b0;
    alu_op      = ALU_ADD;
    mult_en     = 1'b0;
    mult_op     = MUL_LO;
    opa         = '0;
    opb         = '0;
    opc         = '0;
    branch      = 1'b0;
    csr_access  = 1'b0;
    csr_rdata   = '0;
    rf_we       = 1'b0;
    rf_waddr    = '0;
    lsu_ready   = 1'b1;
    wb_ready    = 1'b1;
    taken       = 1'b0;
    tail        = 0;

    @(posedge rst_n);
    @(posedge clk);
    // Idle state straight out of reset
    check_bit("issue_ready_o", issue_ready, 1'b1);
    check_bit("wb_we_o", wb_we, 1'b0);
    check_bit("mult_multicycle_o", mult_multicycle, 1'b0);
    check_bit("branch_valid_o", branch_valid, 1'b0);
    check_bit("fw_we_o", fw_we, 1'b0);

    // Run until everything has drained, then a few idle cycles
    while (tail < 4)
    begin
      @(negedge clk);
      drive_inputs();
      @(posedge clk);
      check_cycle();
      if (accepted_count == N_INSTR && !m_busy && wq_addr.size() == 0 && bq_dec.size() == 0)
      begin
        tail++;
      end
    end

    end_ok = 1'b1;
    if (!multicycle_seen)
    begin
      $display("No high-product multiply was ever seen in progress");
      end_ok = 1'b0;
    end
    if (end_ok)
    begin
      $display("PASS: all tests");
      $finish;
    end
    else
    begin
      stop_on_error();
    end
  end

  // Run limit
  always @(posedge clk)
  begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES)
    begin
      $display("Timeout, the test did not finish within %0d cycles", TIMEOUT_CYCLES);
      stop_on_error();
    end
  end

endmodule

// File: tb/tb_clkgen.sv
// Testbench clock and reset source, 20 ns clock with reset held low for 16 cycles
`timescale 1ns/1ps

module tb_clkgen
(
  output logic clk_o,
  output logic rst_n_o
);

  // 50 MHz free-running clock
  initial
  begin
    clk_o = 1'b0;
    forever #10 clk_o = ~clk_o;
  end

  // Release on a falling edge so the first active edge sees a clean reset
  initial
  begin
    rst_n_o = 1'b0;
    repeat (16) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

// File: hw/ex_top.sv
// Top of the execute stage, joining the ID/EX register, ALU, multiplier and stage control
`timescale 1ns/1ps

module ex_top
  import ex_ops_pkg::*, core_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,

  // Issue from decode
  input  logic      issue_valid_i,
  input  alu_op_e   alu_op_i,
  input  logic      mult_en_i,
  input  mult_op_e  mult_op_i,
  input  word_t     opa_i,
  input  word_t     opb_i,
  input  word_t     opc_i,
  input  logic      branch_i,
  input  logic      csr_access_i,
  input  word_t     csr_rdata_i,
  input  logic      rf_we_i,
  input  reg_addr_t rf_waddr_i,
  output logic      issue_ready_o,

  // Stall levels
  input  logic      lsu_ready_i,
  input  logic      wb_ready_i,

  output logic      fw_we_o,
  output reg_addr_t fw_waddr_o,
  output word_t     fw_wdata_o,

  output logic      branch_valid_o,
  output logic      branch_decision_o,
  output word_t     jump_target_o,

  output logic      wb_we_o,
  output reg_addr_t wb_waddr_o,
  output word_t     wb_wdata_o,

  output logic      mult_multicycle_o
);

  // Stored instruction
  alu_op_e   ex_alu_op;
  logic      ex_mult_en;
  mult_op_e  ex_mult_op;
  word_t     ex_opa;
  word_t     ex_opb;
  word_t     ex_opc;
  logic      ex_branch;
  logic      ex_csr_access;
  word_t     ex_csr_rdata;
  logic      ex_rf_we;
  reg_addr_t ex_rf_waddr;
  logic      ex_busy;

  // Unit outputs
  word_t     alu_result;
  logic      alu_cmp;
  logic      alu_ready;
  word_t     mult_result;
  logic      mult_ready;
  logic      ex_ready;

  assign issue_ready_o = ex_ready;

  ////////////////////////////////////////////////////////////////////
  // ID/EX register
  ////////////////////////////////////////////////////////////////////

  ex_issue_reg issue_reg_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .issue_valid_i (issue_valid_i),
    .alu_op_i      (alu_op_i),
    .mult_en_i     (mult_en_i),
    .mult_op_i     (mult_op_i),
    .opa_i         (opa_i),
    .opb_i         (opb_i),
    .opc_i         (opc_i),
    .branch_i      (branch_i),
    .csr_access_i  (csr_access_i),
    .csr_rdata_i   (csr_rdata_i),
    .rf_we_i       (rf_we_i),
    .rf_waddr_i    (rf_waddr_i),
    .ex_ready_i    (ex_ready),
    .alu_op_o      (ex_alu_op),
    .mult_en_o     (ex_mult_en),
    .mult_op_o     (ex_mult_op),
    .opa_o         (ex_opa),
    .opb_o         (ex_opb),
    .opc_o         (ex_opc),
    .branch_o      (ex_branch),
    .csr_access_o  (ex_csr_access),
    .csr_rdata_o   (ex_csr_rdata),
    .rf_we_o       (ex_rf_we),
    .rf_waddr_o    (ex_rf_waddr),
    .busy_o        (ex_busy)
  );

  ////////////////////////////////////////////////////////////////////
  // Functional units
  ////////////////////////////////////////////////////////////////////

  ex_alu alu_i (
    .clk                 (clk),
    .rst_n               (rst_n),
    .operator_i          (ex_alu_op),
    .operand_a_i         (ex_opa),
    .operand_b_i         (ex_opb),
    .result_o            (alu_result),
    .comparison_result_o (alu_cmp),
    .ready_o             (alu_ready)
  );

  // Multiplier shares operands a and b with the ALU
  ex_mult mult_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .enable_i     (ex_mult_en),
    .operator_i   (ex_mult_op),
    .op_a_i       (ex_opa),
    .op_b_i       (ex_opb),
    .ex_ready_i   (ex_ready),
    .result_o     (mult_result),
    .multicycle_o (mult_multicycle_o),
    .ready_o      (mult_ready)
  );

  ////////////////////////////////////////////////////////////////////
  // Stage control and EX/WB
  ////////////////////////////////////////////////////////////////////

  ex_stage stage_i (
    .clk               (clk),
    .rst_n             (rst_n),
    .busy_i            (ex_busy),
    .mult_en_i         (ex_mult_en),
    .csr_access_i      (ex_csr_access),
    .branch_i          (ex_branch),
    .opc_i             (ex_opc),
    .rf_we_i           (ex_rf_we),
    .rf_waddr_i        (ex_rf_waddr),
    .alu_result_i      (alu_result),
    .mult_result_i     (mult_result),
    .csr_rdata_i       (ex_csr_rdata),
    .alu_cmp_i         (alu_cmp),
    .alu_ready_i       (alu_ready),
    .mult_ready_i      (mult_ready),
    .lsu_ready_i       (lsu_ready_i),
    .wb_ready_i        (wb_ready_i),
    .ex_ready_o        (ex_ready),
    .fw_we_o           (fw_we_o),
    .fw_waddr_o        (fw_waddr_o),
    .fw_wdata_o        (fw_wdata_o),
    .branch_valid_o    (branch_valid_o),
    .branch_decision_o (branch_decision_o),
    .jump_target_o     (jump_target_o),
    .wb_we_o           (wb_we_o),
    .wb_waddr_o        (wb_waddr_o),
    .wb_wdata_o        (wb_wdata_o)
  );

endmodule

// File: hw/ex_stage.sv
// Execute-stage control with result select, forwarding, stall rules and the EX/WB register
`timescale 1ns/1ps

module ex_stage
  import core_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,

  // Instruction in EX
  input  logic      busy_i,
  input  logic      mult_en_i,
  input  logic      csr_access_i,
  input  logic      branch_i,
  input  word_t     opc_i,
  input  logic      rf_we_i,
  input  reg_addr_t rf_waddr_i,

  // Unit results
  input  word_t     alu_result_i,
  input  word_t     mult_result_i,
  input  word_t     csr_rdata_i,
  input  logic      alu_cmp_i,
  input  logic      alu_ready_i,
  input  logic      mult_ready_i,

  // Back-pressure from LSU and WB
  input  logic      lsu_ready_i,
  input  logic      wb_ready_i,

  output logic      ex_ready_o,

  // Forward path to decode
  output logic      fw_we_o,
  output reg_addr_t fw_waddr_o,
  output word_t     fw_wdata_o,

  // Branch outcome to fetch
  output logic      branch_valid_o,
  output logic      branch_decision_o,
  output word_t     jump_target_o,

  // EX/WB register
  output logic      wb_we_o,
  output reg_addr_t wb_waddr_o,
  output word_t     wb_wdata_o
);

  logic units_ready;
  logic ex_valid;

  // Multiplier first, then CSR, then ALU
  assign fw_wdata_o = mult_en_i    ? mult_result_i :
                      csr_access_i ? csr_rdata_i   :
                                     alu_result_i;

  // Branches never write a register
  assign fw_we_o    = rf_we_i & busy_i & ~branch_i;
  assign fw_waddr_o = rf_waddr_i;

  assign branch_valid_o    = branch_i & busy_i;
  assign branch_decision_o = alu_cmp_i;
  assign jump_target_o     = opc_i;

  ////////////////////////////////////////////////////////////////////
  // Stall rules
  ////////////////////////////////////////////////////////////////////

  assign units_ready = alu_ready_i & mult_ready_i & lsu_ready_i & wb_ready_i;

  // Valid heads right and ready heads left, so valid ignores ex_ready
  assign ex_valid = units_ready & busy_i;

  // A branch resolves in EX and can leave even when LSU or WB stall
  assign ex_ready_o = units_ready | (branch_i & busy_i) | (~busy_i & wb_ready_i);

  ////////////////////////////////////////////////////////////////////
  // EX/WB register
  ////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      wb_we_o <= 1'b0;
    end
    else if (ex_valid)
    begin
      wb_we_o <= fw_we_o;
    end
    else if (wb_ready_i)
    begin
      // Nothing new arrives, so flush the old write
      wb_we_o <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (ex_valid && fw_we_o)
    begin
      wb_waddr_o <= fw_waddr_o;
      wb_wdata_o <= fw_wdata_o;
    end
  end

endmodule

// File: hw/ex_mult.sv
// Integer multiplier for the execute stage, low product in one cycle and high products in three
`timescale 1ns/1ps

module ex_mult
  import ex_ops_pkg::*, core_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,

  input  logic     enable_i,
  input  mult_op_e operator_i,
  input  word_t    op_a_i,
  input  word_t    op_b_i,

  // Result is consumed when the stage is ready
  input  logic     ex_ready_i,

  output word_t    result_o,
  output logic     multicycle_o,
  output logic     ready_o
);

  typedef enum logic [1:0] {
    MS_IDLE,
    MS_STEP,
    MS_FINISH
  } mult_state_e;

  mult_state_e state_q;
  mult_state_e state_d;

  logic               high_op;
  logic               sign_a;
  logic               sign_b;
  logic signed [32:0] a_ext;
  logic signed [32:0] b_ext;
  logic signed [16:0] a_lo;
  logic signed [16:0] a_hi;
  logic signed [49:0] pp_lo;
  logic signed [49:0] pp_hi;
  logic signed [65:0] acc_q;
  word_t              low_result;

  ////////////////////////////////////////////////////////////////////
  // Operand preparation
  ////////////////////////////////////////////////////////////////////

  assign high_op = enable_i & (operator_i != MUL_LO);

  // HSU treats only a as signed
  assign sign_a = (operator_i == MUL_HSS) || (operator_i == MUL_HSU);
  assign sign_b = (operator_i == MUL_HSS);

  assign a_ext = {sign_a & op_a_i[XLEN-1], op_a_i};
  assign b_ext = {sign_b & op_b_i[XLEN-1], op_b_i};

  // Lower half of a is always a positive 16-bit slice
  assign a_lo = {1'b0, a_ext[15:0]};
  assign a_hi = a_ext[32:16];

  // Two 16x33 partial products
  assign pp_lo = 50'(a_lo) * 50'(b_ext);
  assign pp_hi = 50'(a_hi) * 50'(b_ext);

  // Low word does not depend on signedness
  assign low_result = op_a_i * op_b_i;

  ////////////////////////////////////////////////////////////////////
  // Sequencing
  ////////////////////////////////////////////////////////////////////

  always_comb
  begin
    state_d = state_q;
    ready_o = 1'b1;
    unique case (state_q)
      MS_IDLE:
      begin
        // Lower partial product goes into the accumulator now
        if (high_op)
        begin
          ready_o = 1'b0;
          state_d = MS_STEP;
        end
      end
      MS_STEP:
      begin
        ready_o = 1'b0;
        state_d = MS_FINISH;
      end
      MS_FINISH:
      begin
        // Hold the product until the stage moves on
        if (ex_ready_i)
        begin
          state_d = MS_IDLE;
        end
      end
      default: state_d = MS_IDLE;
    endcase
  end

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_q <= MS_IDLE;
    end
    else
    begin
      state_q <= state_d;
    end
  end

  // Upper partial product is weighted by 2^16
  always_ff @(posedge clk)
  begin
    if (state_q == MS_IDLE && high_op)
    begin
      acc_q <= 66'(pp_lo);
    end
    else if (state_q == MS_STEP)
    begin
      acc_q <= acc_q + (66'(pp_hi) <<< 16);
    end
  end

  assign result_o     = (operator_i == MUL_LO) ? low_result : acc_q[63:32];
  assign multicycle_o = (state_q != MS_IDLE);

endmodule

// File: hw/ex_alu.sv
// Single-cycle integer ALU for the execute stage, also producing the branch comparison flag
`timescale 1ns/1ps

module ex_alu
  import ex_ops_pkg::*, core_pkg::*;
(
  // Reserved for a later multi-cycle operation such as divide
  input  logic    clk,
  input  logic    rst_n,

  input  alu_op_e operator_i,
  input  word_t   operand_a_i,
  input  word_t   operand_b_i,

  output word_t   result_o,
  output logic    comparison_result_o,
  output logic    ready_o
);

  // Bit reversal lets one right shifter serve left shifts too
  function automatic word_t bit_rev(input word_t v);
    word_t r;
    for (int i = 0; i < XLEN; i++)
    begin
      r[i] = v[XLEN-1-i];
    end
    return r;
  endfunction

  logic               adder_sub;
  word_t              adder_b;
  logic [XLEN:0]      adder_sum;
  logic               is_equal;
  logic               less_signed;
  logic               less_unsigned;
  logic               shift_left;
  logic [4:0]         shamt;
  word_t              shift_in;
  logic signed [XLEN:0] shift_ext;
  word_t              shift_right;
  word_t              shift_result;

  ////////////////////////////////////////////////////////////////////
  // Shared adder
  ////////////////////////////////////////////////////////////////////

  // Everything except ADD runs as a - b
  assign adder_sub = (operator_i != ALU_ADD);
  assign adder_b   = adder_sub ? ~operand_b_i : operand_b_i;
  assign adder_sum = {1'b0, operand_a_i} + {1'b0, adder_b} + {{XLEN{1'b0}}, adder_sub};

  // Zero difference means equal operands
  assign is_equal = (adder_sum[XLEN-1:0] == '0);

  // Differing signs decide directly, otherwise the difference sign does
  assign less_signed = (operand_a_i[XLEN-1] ^ operand_b_i[XLEN-1]) ?
                       operand_a_i[XLEN-1] : adder_sum[XLEN-1];

  // No carry out of a - b is a borrow
  assign less_unsigned = ~adder_sum[XLEN];

  ////////////////////////////////////////////////////////////////////
  // Barrel shifter
  ////////////////////////////////////////////////////////////////////

  assign shift_left  = (operator_i == ALU_SLL);
  assign shamt       = operand_b_i[4:0];
  assign shift_in    = shift_left ? bit_rev(operand_a_i) : operand_a_i;

  // Extra top bit carries the sign for SRA only
  assign shift_ext   = {(operator_i == ALU_SRA) & shift_in[XLEN-1], shift_in};
  assign shift_right = word_t'(shift_ext >>> shamt);

  assign shift_result = shift_left ? bit_rev(shift_right) : shift_right;

  ////////////////////////////////////////////////////////////////////
  // Result and comparison
  ////////////////////////////////////////////////////////////////////

  always_comb
  begin
    result_o = '0;
    unique case (operator_i)
      ALU_ADD,
      ALU_SUB:  result_o = adder_sum[XLEN-1:0];
      ALU_AND:  result_o = operand_a_i & operand_b_i;
      ALU_OR:   result_o = operand_a_i | operand_b_i;
      ALU_XOR:  result_o = operand_a_i ^ operand_b_i;
      ALU_SLL,
      ALU_SRL,
      ALU_SRA:  result_o = shift_result;
      ALU_SLT:  result_o = {{(XLEN-1){1'b0}}, less_signed};
      ALU_SLTU: result_o = {{(XLEN-1){1'b0}}, less_unsigned};
      // Branch compares leave the result at zero
      default:  result_o = '0;
    endcase
  end

  always_comb
  begin
    comparison_result_o = 1'b0;
    unique case (operator_i)
      ALU_EQ:  comparison_result_o = is_equal;
      ALU_NE:  comparison_result_o = ~is_equal;
      ALU_LT:  comparison_result_o = less_signed;
      ALU_GE:  comparison_result_o = ~less_signed;
      default: comparison_result_o = 1'b0;
    endcase
  end

  // All current ops finish in the cycle they arrive
  assign ready_o = 1'b1;

endmodule

// File: hw/ex_issue_reg.sv
// ID/EX pipeline register that captures one decoded instruction and holds it while EX stalls
`timescale 1ns/1ps

module ex_issue_reg
  import ex_ops_pkg::*, core_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,

  // From decode
  input  logic      issue_valid_i,
  input  alu_op_e   alu_op_i,
  input  logic      mult_en_i,
  input  mult_op_e  mult_op_i,
  input  word_t     opa_i,
  input  word_t     opb_i,
  input  word_t     opc_i,
  input  logic      branch_i,
  input  logic      csr_access_i,
  input  word_t     csr_rdata_i,
  input  logic      rf_we_i,
  input  reg_addr_t rf_waddr_i,

  // Stage can take a new instruction
  input  logic      ex_ready_i,

  // Stored copy towards EX
  output alu_op_e   alu_op_o,
  output logic      mult_en_o,
  output mult_op_e  mult_op_o,
  output word_t     opa_o,
  output word_t     opb_o,
  output word_t     opc_o,
  output logic      branch_o,
  output logic      csr_access_o,
  output word_t     csr_rdata_o,
  output logic      rf_we_o,
  output reg_addr_t rf_waddr_o,
  output logic      busy_o
);

  // Control bits drop to zero on a bubble so no unit acts on stale fields
  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      busy_o       <= 1'b0;
      mult_en_o    <= 1'b0;
      branch_o     <= 1'b0;
      csr_access_o <= 1'b0;
      rf_we_o      <= 1'b0;
    end
    else if (ex_ready_i)
    begin
      busy_o       <= issue_valid_i;
      mult_en_o    <= issue_valid_i & mult_en_i;
      branch_o     <= issue_valid_i & branch_i;
      csr_access_o <= issue_valid_i & csr_access_i;
      rf_we_o      <= issue_valid_i & rf_we_i;
    end
  end

  // Operation and operand fields
  always_ff @(posedge clk)
  begin
    if (ex_ready_i && issue_valid_i)
    begin
      alu_op_o    <= alu_op_i;
      mult_op_o   <= mult_op_i;
      opa_o       <= opa_i;
      opb_o       <= opb_i;
      opc_o       <= opc_i;
      csr_rdata_o <= csr_rdata_i;
      rf_waddr_o  <= rf_waddr_i;
    end
  end

endmodule

// File: hw/ex_ops_pkg.sv
// Opcode enums for the ALU and the multiplier, imported by the issue register and both units
package ex_ops_pkg;

  ////////////////////////////////////////////////////////////////////
  // ALU operations
  ////////////////////////////////////////////////////////////////////

  // Arithmetic, logic and shifts write a result
  // Branch compares only drive the comparison flag
  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_AND  = 4'd2,
    ALU_OR   = 4'd3,
    ALU_XOR  = 4'd4,
    ALU_SLL  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_SLT  = 4'd8,
    ALU_SLTU = 4'd9,
    ALU_EQ   = 4'd10,
    ALU_NE   = 4'd11,
    ALU_LT   = 4'd12,
    ALU_GE   = 4'd13
  } alu_op_e;

  ////////////////////////////////////////////////////////////////////
  // Multiplier operations
  ////////////////////////////////////////////////////////////////////

  // Low product in one cycle, high products take three
  typedef enum logic [1:0] {
    MUL_LO  = 2'd0,
    MUL_HSS = 2'd1,
    MUL_HUU = 2'd2,
    MUL_HSU = 2'd3
  } mult_op_e;

endpackage

// File: hw/core_pkg.sv
// Core-wide data and register-index widths with their types, shared by all execute-stage blocks
package core_pkg;

  // Integer datapath width
  localparam int XLEN = 32;

  // Register file has 32 entries
  localparam int REG_AW = 5;

  // One data word
  typedef logic [XLEN-1:0] word_t;

  // Register index
  typedef logic [REG_AW-1:0] reg_addr_t;

endpackage
